/* bench/mem_stimulus.txt */
# columns: port (i, d, or b for a barrier), op (r or w), byte address, select,
# write data, expected read data (all hex, expected is ignored for writes)
d w 00100 f 11111111 00000000
d w 00104 f 22222222 00000000
d w 00108 f 33333333 00000000
d w 0010c f 44444444 00000000
d r 00104 f 00000000 22222222
d r 00100 f 00000000 11111111
d r 0010c f 00000000 44444444
d r 00108 f 00000000 33333333
d w 00200 1 000000aa 00000000
d w 00200 2 0000bb00 00000000
d w 00200 4 00cc0000 00000000
d w 00200 8 dd000000 00000000
d r 00200 f 00000000 ddccbbaa
d w 00200 3 00001234 00000000
d w 00200 c 56780000 00000000
d r 00200 f 00000000 56781234
d w 00300 f 0badf00d 00000000
b - 00000 0 00000000 00000000
i r 00100 f 00000000 11111111
i r 00104 f 00000000 22222222
i r 00108 f 00000000 33333333
i r 0010c f 00000000 44444444
i r 00200 f 00000000 56781234
i r 00300 f 00000000 0badf00d
d r 00300 f 00000000 0badf00d
d r 00108 f 00000000 33333333
d r 00200 f 00000000 56781234
d w 00400 f cafef00d 00000000
d r 00400 f 00000000 cafef00d
b - 00000 0 00000000 00000000
d w 00300 f 600df00d 00000000
d w 00104 2 0000ee00 00000000
b - 00000 0 00000000 00000000
i r 00300 f 00000000 600df00d
i r 00104 f 00000000 2222ee22
i r 00400 f 00000000 cafef00d
d r 00300 f 00000000 600df00d
d r 00104 f 00000000 2222ee22

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);

	// 10 ns period, first rising edge at 5 ns
	initial begin
		clk_o = 1'b0;
		forever begin
			#5 clk_o = ~clk_o;
		end
	end

endmodule

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsystem;

	import mem_types_pkg::*;
	import wb_types_pkg::*;

	localparam int MAX_ENTRIES = 128;
	localparam int ACK_LIMIT = 40;

	logic clk;
	logic rst_n;
	wb_m2s_t ibus_m;
	wb_m2s_t dbus_m;
	wb_s2m_t ibus_s;
	wb_s2m_t dbus_s;

	logic [7:0] ent_port [MAX_ENTRIES];
	logic [7:0] ent_op [MAX_ENTRIES];
	mem_addr_t ent_addr [MAX_ENTRIES];
	logic [`MEM_SEL_W-1:0] ent_sel [MAX_ENTRIES];
	mem_word_t ent_wdata [MAX_ENTRIES];
	mem_word_t ent_expect [MAX_ENTRIES];
	int ent_line [MAX_ENTRIES];
	int n_entries;

	int errors;
	int transfers;
	int bars [2];
	bit loaded;

	tb_clock u_clock (
		.clk_o (clk)
	);

	mem_subsystem uut (
		.clk     (clk),
		.rst_n_i (rst_n),
		.ibus_i  (ibus_m),
		.ibus_o  (ibus_s),
		.dbus_i  (dbus_m),
		.dbus_o  (dbus_s)
	);

	task automatic load_stimulus();
		int fd;
		int line_no;
		int count;
		string text;
		logic [7:0] p;
		logic [7:0] o;
		logic [31:0] a;
		logic [31:0] s;
		logic [31:0] w;
		logic [31:0] e;
		n_entries = 0;
		line_no = 0;
		fd = $fopen("bench/mem_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("error: cannot open the stimulus file bench/mem_stimulus.txt");
		end else begin
			while ($fgets(text, fd) != 0) begin
				line_no++;
				// blank lines and lines starting with # carry no transfer
				if (text.len() > 1 && text.getc(0) != "#" && n_entries < MAX_ENTRIES) begin
					count = $sscanf(text, "%c %c %h %h %h %h", p, o, a, s, w, e);
					if (count == 6) begin
						ent_port[n_entries] = p;
						ent_op[n_entries] = o;
						ent_addr[n_entries] = a[`MEM_ADDR_W-1:0];
						ent_sel[n_entries] = s[`MEM_SEL_W-1:0];
						ent_wdata[n_entries] = w;
						ent_expect[n_entries] = e;
						ent_line[n_entries] = line_no;
						n_entries++;
					end else begin
						errors++;
						$display("error: stimulus line %0d could not be parsed", line_no);
					end
				end
			end
			$fclose(fd);
		end
		if (n_entries == 0) begin
			errors++;
			$display("error: the stimulus file holds no transfers");
		end
	endtask

	task automatic check_acks_low(input string phase);
		if (ibus_s.ack !== 1'b0) begin
			errors++;
			$display("MISMATCH ibus_o.ack %s: got %h, expected 0", phase, ibus_s.ack);
		end
		if (dbus_s.ack !== 1'b0) begin
			errors++;
			$display("MISMATCH dbus_o.ack %s: got %h, expected 0", phase, dbus_s.ack);
		end
	endtask

	task automatic drive_bus(input int port, input wb_m2s_t m);
		if (port == 0) begin
			ibus_m <= m;
		end else begin
			dbus_m <= m;
		end
	endtask

	// walks the file in order and takes the lines of one port
	task automatic run_port(input int port);
		int k;
		int gap;
		int waited;
		bit got;
		bit mine;
		string name;
		wb_m2s_t m;
		wb_s2m_t r;
		name = (port == 0) ? "ibus_o" : "dbus_o";
		for (k = 0; k < n_entries; k++) begin
			mine = (port == 0 && ent_port[k] == "i") || (port == 1 && ent_port[k] == "d");
			if (ent_port[k] == "b") begin
				bars[port]++;
				while (bars[1 - port] < bars[port]) begin
					@(posedge clk);
				end
			end else if (mine) begin
				gap = $urandom % 4;
				repeat (gap) @(posedge clk);
				@(posedge clk);
				m = '0;
				m.cyc = 1'b1;
				m.stb = 1'b1;
				m.we = (ent_op[k] == "w");
				m.adr = ent_addr[k];
				m.sel = ent_sel[k];
				m.dat = ent_wdata[k];
				drive_bus(port, m);
				got = 1'b0;
				waited = 0;
				while (!got && waited < ACK_LIMIT) begin
					@(posedge clk);
					r = (port == 0) ? ibus_s : dbus_s;
					got = (r.ack === 1'b1);
					waited++;
				end
				drive_bus(port, '0);
				transfers++;
				if (!got) begin
					errors++;
					$display("error: no ack on %s within %0d cycles for stimulus line %0d",
						name, ACK_LIMIT, ent_line[k]);
				end else if (!m.we && r.dat !== ent_expect[k]) begin
					errors++;
					$display("MISMATCH %s.dat at address %h: got %h, expected %h",
						name, ent_addr[k], r.dat, ent_expect[k]);
				end
			end
		end
	endtask

	initial begin
		ibus_m = '0;
		dbus_m = '0;
		rst_n = 1'b0;
		errors = 0;
		transfers = 0;
		bars[0] = 0;
		bars[1] = 0;
		void'($urandom(77468));
		load_stimulus();
		loaded = 1'b1;
		@(negedge clk);
		check_acks_low("during reset");
		// the next rising edge is the second one that samples reset low
		@(posedge clk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_acks_low("after reset");
		end
		fork
			run_port(0);
			run_port(1);
		join
		$display("transfers: %0d, errors: %0d", transfers, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// forty cycles for every line of the file, plus the reset sequence
	initial begin
		wait (loaded);
		repeat (n_entries * 40 + 20) @(posedge clk);
		$display("error: watchdog expired before all transfers finished, errors so far: %0d",
			errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* design/line_arbiter.sv */
`timescale 1ns/1ps

module line_arbiter (
	input logic clk,
	input logic rst_n_i,
	input mem_types_pkg::line_req_t ireq_i,
	input mem_types_pkg::line_req_t dreq_i,
	output mem_types_pkg::line_rsp_t irsp_o,
	output mem_types_pkg::line_rsp_t drsp_o,
	output logic iwr_done_o,
	output logic dwr_done_o,
	output mem_types_pkg::line_req_t mem_req_o,
	input mem_types_pkg::line_rsp_t mem_rsp_i,
	output logic snoop_valid_o,
	output mem_types_pkg::mem_addr_t snoop_addr_o
);

	import mem_types_pkg::*;

	logic grant_i;
	logic grant_d;

	// a read is outstanding for exactly the cycle its response is returned
	logic busy_q;
	// set when the outstanding read belongs to the data port
	logic owner_d_q;

	always_comb begin
		grant_i = 1'b0;
		grant_d = 1'b0;
		mem_req_o = dreq_i;
		mem_req_o.op = LINE_IDLE;
		if (!busy_q) begin
			// data port wins a tie
			if (dreq_i.op != LINE_IDLE) begin
				grant_d = 1'b1;
				mem_req_o = dreq_i;
			end else if (ireq_i.op != LINE_IDLE) begin
				grant_i = 1'b1;
				mem_req_o = ireq_i;
			end
		end
	end

	assign iwr_done_o = grant_i && (ireq_i.op == LINE_WRITE);
	assign dwr_done_o = grant_d && (dreq_i.op == LINE_WRITE);

	// only data writes are snooped by the instruction buffer
	assign snoop_valid_o = dwr_done_o;
	assign snoop_addr_o = dreq_i.addr;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			owner_d_q <= 1'b0;
		end else begin
			busy_q <= (mem_req_o.op == LINE_READ);
			if (mem_req_o.op == LINE_READ) begin
				owner_d_q <= grant_d;
			end
		end
	end

	// the line goes to both, ready only to the owner
	always_comb begin
		irsp_o = mem_rsp_i;
		irsp_o.ready = mem_rsp_i.ready && !owner_d_q;
		drsp_o = mem_rsp_i;
		drsp_o.ready = mem_rsp_i.ready && owner_d_q;
	end

endmodule

/* design/line_buffer.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module line_buffer (
	input logic clk,
	input logic rst_n_i,
	input wb_types_pkg::wb_m2s_t wb_i,
	output wb_types_pkg::wb_s2m_t wb_o,
	output mem_types_pkg::line_req_t mem_req_o,
	input mem_types_pkg::line_rsp_t mem_rsp_i,
	input logic wr_done_i,
	input logic snoop_valid_i,
	input mem_types_pkg::mem_addr_t snoop_addr_i
);

	import mem_types_pkg::*;
	import wb_types_pkg::*;

	typedef enum logic [1:0] {
		BUF_IDLE  = 2'd0,
		BUF_FILL  = 2'd1,
		BUF_WRITE = 2'd2,
		BUF_ACK   = 2'd3
	} buf_state_e;

	buf_state_e state_q;
	buf_state_e state_d;

	mem_line_t line_q;
	logic [`MEM_INDEX_W-1:0] tag_q;
	logic valid_q;

	logic [`MEM_INDEX_W-1:0] req_tag;
	logic [`MEM_OFFSET_W-3:0] word_idx;
	logic req_active;
	logic hit;
	logic snoop_hit;

	// the tag is the line index, matching how the array aliases addresses
	assign req_tag = wb_i.adr[`MEM_OFFSET_W +: `MEM_INDEX_W];
	assign word_idx = wb_i.adr[`MEM_OFFSET_W-1:2];
	assign req_active = wb_i.cyc && wb_i.stb;
	assign hit = valid_q && (tag_q == req_tag);
	assign snoop_hit = snoop_valid_i && valid_q &&
		(snoop_addr_i[`MEM_OFFSET_W +: `MEM_INDEX_W] == tag_q);

	always_comb begin
		state_d = state_q;
		case (state_q)
			BUF_IDLE: begin
				if (req_active) begin
					if (wb_i.we) begin
						state_d = BUF_WRITE;
					end else if (hit) begin
						state_d = BUF_ACK;
					end else begin
						state_d = BUF_FILL;
					end
				end
			end
			BUF_FILL: begin
				if (mem_rsp_i.ready) begin
					state_d = BUF_ACK;
				end
			end
			BUF_WRITE: begin
				if (wr_done_i) begin
					state_d = BUF_ACK;
				end
			end
			default: begin
				// the master sees ack in this cycle and moves on at the edge
				state_d = BUF_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= BUF_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// a write to the held line from the other port makes it stale
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (snoop_hit) begin
			valid_q <= 1'b0;
		end else if (state_q == BUF_FILL && mem_rsp_i.ready) begin
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == BUF_FILL && mem_rsp_i.ready) begin
			line_q <= mem_rsp_i.line;
			tag_q <= mem_rsp_i.addr[`MEM_OFFSET_W +: `MEM_INDEX_W];
		end else if (state_q == BUF_WRITE && wr_done_i && hit) begin
			// keep the held copy in step with memory, lane by lane
			for (int b = 0; b < `MEM_SEL_W; b++) begin
				if (wb_i.sel[b]) begin
					line_q[word_idx * `MEM_WORD_W + b * 8 +: 8] <= wb_i.dat[b * 8 +: 8];
				end
			end
		end
	end

	always_comb begin
		mem_req_o.op = LINE_IDLE;
		if (state_q == BUF_FILL) begin
			mem_req_o.op = LINE_READ;
		end else if (state_q == BUF_WRITE) begin
			mem_req_o.op = LINE_WRITE;
		end
		mem_req_o.addr = wb_i.adr;
		mem_req_o.sel = wb_i.sel;
		mem_req_o.wdata = wb_i.dat;
	end

	// read data comes from the held line, also right after a fill
	always_comb begin
		wb_o.ack = (state_q == BUF_ACK);
		wb_o.dat = line_q[word_idx * `MEM_WORD_W +: `MEM_WORD_W];
	end

endmodule

/* design/line_memory.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module line_memory (
	input logic clk,
	input logic rst_n_i,
	input mem_types_pkg::line_req_t req_i,
	output mem_types_pkg::line_rsp_t rsp_o
);

	import mem_types_pkg::*;

	mem_line_t mem_array [`MEM_DEPTH];

	logic [`MEM_INDEX_W-1:0] index;
	logic [`MEM_OFFSET_W-3:0] word_idx;

	logic rsp_ready_q;
	mem_addr_t rsp_addr_q;
	mem_line_t rsp_line_q;

	// upper address bits beyond the index alias onto the same lines
	assign index = req_i.addr[`MEM_OFFSET_W +: `MEM_INDEX_W];
	assign word_idx = req_i.addr[`MEM_OFFSET_W-1:2];

	// byte and word writes are the same rule, only the selected lanes change
	always_ff @(posedge clk) begin
		if (req_i.op == LINE_WRITE) begin
			for (int b = 0; b < `MEM_SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem_array[index][word_idx * `MEM_WORD_W + b * 8 +: 8] <=
						req_i.wdata[b * 8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rsp_ready_q <= 1'b0;
		end else begin
			rsp_ready_q <= (req_i.op == LINE_READ);
		end
	end

	// the whole line and the requested address come back one cycle later
	always_ff @(posedge clk) begin
		if (req_i.op == LINE_READ) begin
			rsp_line_q <= mem_array[index];
			rsp_addr_q <= req_i.addr;
		end
	end

	always_comb begin
		rsp_o.ready = rsp_ready_q;
		rsp_o.addr = rsp_addr_q;
		rsp_o.line = rsp_line_q;
	end

endmodule

/* design/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address width on both ports and on the line interface
`define MEM_ADDR_W 20

// one memory line holds four words
`define MEM_LINE_W 128
`define MEM_WORD_W 32

// one select bit per byte lane of a word
`define MEM_SEL_W (`MEM_WORD_W / 8)

// line index and byte offset inside a line
`define MEM_INDEX_W 12
`define MEM_OFFSET_W 4

// number of lines in the array
`define MEM_DEPTH (1 << `MEM_INDEX_W)

`endif

/* design/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
	input logic clk,
	input logic rst_n_i,
	input wb_types_pkg::wb_m2s_t ibus_i,
	output wb_types_pkg::wb_s2m_t ibus_o,
	input wb_types_pkg::wb_m2s_t dbus_i,
	output wb_types_pkg::wb_s2m_t dbus_o
);

	import mem_types_pkg::*;
	import wb_types_pkg::*;

	wb_m2s_t ibus_rd;

	line_req_t ireq;
	line_req_t dreq;
	line_rsp_t irsp;
	line_rsp_t drsp;
	logic iwr_done;
	logic dwr_done;

	line_req_t mem_req;
	line_rsp_t mem_rsp;

	logic snoop_valid;
	mem_addr_t snoop_addr;

	// the instruction port is read only, a write there is served as a read and acked
	always_comb begin
		ibus_rd = ibus_i;
		ibus_rd.we = 1'b0;
	end

	line_buffer u_ibuf (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.wb_i          (ibus_rd),
		.wb_o          (ibus_o),
		.mem_req_o     (ireq),
		.mem_rsp_i     (irsp),
		.wr_done_i     (iwr_done),
		.snoop_valid_i (snoop_valid),
		.snoop_addr_i  (snoop_addr)
	);

	// the data buffer updates its own line on writes, so it needs no snoop
	line_buffer u_dbuf (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.wb_i          (dbus_i),
		.wb_o          (dbus_o),
		.mem_req_o     (dreq),
		.mem_rsp_i     (drsp),
		.wr_done_i     (dwr_done),
		.snoop_valid_i (1'b0),
		.snoop_addr_i  ('0)
	);

	line_arbiter u_arbiter (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.ireq_i        (ireq),
		.dreq_i        (dreq),
		.irsp_o        (irsp),
		.drsp_o        (drsp),
		.iwr_done_o    (iwr_done),
		.dwr_done_o    (dwr_done),
		.mem_req_o     (mem_req),
		.mem_rsp_i     (mem_rsp),
		.snoop_valid_o (snoop_valid),
		.snoop_addr_o  (snoop_addr)
	);

	line_memory u_memory (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (mem_req),
		.rsp_o   (mem_rsp)
	);

endmodule

/* design/mem_types_pkg.sv */
`include "mem_consts.svh"

package mem_types_pkg;

	// byte address as seen on both ports
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

	typedef logic [`MEM_WORD_W-1:0] mem_word_t;

	// word 0 sits in the low bits of a line
	typedef logic [`MEM_LINE_W-1:0] mem_line_t;

	// operation carried on the internal line interface
	typedef enum logic [1:0] {
		LINE_IDLE  = 2'd0,
		LINE_READ  = 2'd1,
		LINE_WRITE = 2'd2
	} line_op_e;

	// request from a buffer, held until it is answered
	typedef struct packed {
		line_op_e op;
		mem_addr_t addr;
		logic [`MEM_SEL_W-1:0] sel;
		mem_word_t wdata;
	} line_req_t;

	// read response, ready is a single cycle pulse
	typedef struct packed {
		logic ready;
		mem_addr_t addr;
		mem_line_t line;
	} line_rsp_t;

endpackage

/* design/wb_types_pkg.sv */
`include "mem_consts.svh"

package wb_types_pkg;

	// master to slave signals of one Wishbone classic port
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		mem_types_pkg::mem_addr_t adr;
		logic [`MEM_SEL_W-1:0] sel;
		mem_types_pkg::mem_word_t dat;
	} wb_m2s_t;

	// slave to master signals, dat is only valid while ack is high
	typedef struct packed {
		logic ack;
		mem_types_pkg::mem_word_t dat;
	} wb_s2m_t;

endpackage

/* tb.f */
+incdir+design
design/mem_types_pkg.sv
design/wb_types_pkg.sv
design/line_memory.sv
design/line_buffer.sv
design/line_arbiter.sv
design/mem_subsystem.sv
bench/tb_clock.sv
bench/tb_mem_subsystem.sv
